// ==== list.f ====
+incdir+source
source/dma_pkg.sv
source/flit_fifo.sv
source/send_dma.sv
source/receive_dma.sv
source/ni_dma_top.sv
test/ni_dma_chk.sv
test/ni_dma_tb.sv

// ==== source/dma_cfg.svh ====
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// data word, also the data part of a flit
`define DMA_DW 32

// address width of the read and write masters
`define DMA_AW 32

// transaction sizes and word counters
`define DMA_SIZEW 10

// flit entries in the loopback buffer
// must stay a power of two so the pointers wrap on their own
`define DMA_FIFO_DEPTH 8

`endif

// ==== source/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    // wishbone cycle type tag
    typedef enum logic [2:0] {
        CLASSIC          = 3'b000,
        CONST_ADDR_BURST = 3'b010,
        INCREMENT_BURST  = 3'b011,
        END_OF_BURST     = 3'b111
    } cti_t;

    typedef enum logic [3:0] {
        SEND_IDLE = 4'b0001,
        SEND_HDR  = 4'b0010,
        SEND_BODY = 4'b0100,
        SEND_WAIT = 4'b1000   // buffer full, resume later
    } send_state_t;

    typedef enum logic [3:0] {
        RECV_IDLE      = 4'b0001,
        RECV_READ_FIFO = 4'b0010,
        RECV_ACTIVE    = 4'b0100,
        RECV_RELEASE   = 4'b1000   // bus released, buffer ran dry
    } recv_state_t;

endpackage

`default_nettype wire

// ==== source/flit_fifo.sv ====
`default_nettype none
`include "dma_cfg.svh"

module flit_fifo (
    input  wire               clk,
    input  wire               reset,
    input  wire               push_i,
    input  wire [`DMA_DW-1:0] push_dat_i,
    input  wire               push_tail_i,
    input  wire               pop_i,
    output logic [`DMA_DW-1:0] head_dat_o,
    output logic              head_tail_o,
    output logic              full_o,
    output logic              empty_o
);

    localparam int PW = $clog2(`DMA_FIFO_DEPTH);

    // tail flag sits in the top bit of each entry
    logic [`DMA_DW:0] mem [`DMA_FIFO_DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [PW:0]      count;   // one bit wider than the pointers
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (count == (PW+1)'(`DMA_FIFO_DEPTH));
    assign empty_o = (count == '0);

    // show-ahead head entry
    assign head_dat_o  = mem[rd_ptr][`DMA_DW-1:0];
    assign head_tail_o = mem[rd_ptr][`DMA_DW];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= {push_tail_i, push_dat_i};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/ni_dma_top.sv ====
`default_nettype none
`include "dma_cfg.svh"

module ni_dma_top
    import dma_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    // send side
    input  wire                   send_start_i,
    input  wire [`DMA_AW-1:0]     send_start_addr_i,
    input  wire [`DMA_SIZEW-1:0]  send_data_size_i,
    input  wire [`DMA_DW-1:0]     send_hdr_i,
    output logic                  rd_cyc_o,
    output logic                  rd_stb_o,
    output logic [`DMA_AW-1:0]    rd_addr_o,
    output cti_t                  rd_cti_o,
    input  wire [`DMA_DW-1:0]     rd_dat_i,
    input  wire                   rd_ack_i,
    output logic                  send_busy_o,
    output logic                  send_done_o,
    // receive side
    input  wire                   receive_start_i,
    input  wire [`DMA_AW-1:0]     receive_start_addr_i,
    input  wire [`DMA_SIZEW-1:0]  max_buff_size_i,
    output logic                  wr_cyc_o,
    output logic                  wr_stb_o,
    output logic                  wr_we_o,
    output logic [`DMA_AW-1:0]    wr_addr_o,
    output logic [`DMA_DW-1:0]    wr_dat_o,
    output cti_t                  wr_cti_o,
    input  wire                   wr_ack_i,
    output logic [`DMA_DW-1:0]    hdr_o,
    output logic [`DMA_SIZEW-1:0] receive_count_o,
    output logic                  receive_busy_o,
    output logic                  receive_done_o,
    output logic [7:0]            status_o
);

    logic               push;
    logic [`DMA_DW-1:0] push_dat;
    logic               push_tail;
    logic               fifo_full;
    logic               pop;
    logic [`DMA_DW-1:0] head_dat;
    logic               head_tail;
    logic               fifo_empty;
    send_state_t        send_state;
    recv_state_t        recv_state;

    assign status_o = {recv_state, send_state};   // receive state in the upper nibble

    send_dma send_dma_i (
        .clk               (clk),
        .reset             (reset),
        .send_start_i      (send_start_i),
        .send_start_addr_i (send_start_addr_i),
        .send_data_size_i  (send_data_size_i),
        .send_hdr_i        (send_hdr_i),
        .rd_cyc_o          (rd_cyc_o),
        .rd_stb_o          (rd_stb_o),
        .rd_addr_o         (rd_addr_o),
        .rd_cti_o          (rd_cti_o),
        .rd_dat_i          (rd_dat_i),
        .rd_ack_i          (rd_ack_i),
        .push_o            (push),
        .push_dat_o        (push_dat),
        .push_tail_o       (push_tail),
        .fifo_full_i       (fifo_full),
        .send_busy_o       (send_busy_o),
        .send_done_o       (send_done_o),
        .send_state_o      (send_state)
    );

    flit_fifo flit_fifo_i (
        .clk         (clk),
        .reset       (reset),
        .push_i      (push),
        .push_dat_i  (push_dat),
        .push_tail_i (push_tail),
        .pop_i       (pop),
        .head_dat_o  (head_dat),
        .head_tail_o (head_tail),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    receive_dma receive_dma_i (
        .clk                  (clk),
        .reset                (reset),
        .receive_start_i      (receive_start_i),
        .receive_start_addr_i (receive_start_addr_i),
        .max_buff_size_i      (max_buff_size_i),
        .pop_o                (pop),
        .head_dat_i           (head_dat),
        .head_tail_i          (head_tail),
        .fifo_empty_i         (fifo_empty),
        .wr_cyc_o             (wr_cyc_o),
        .wr_stb_o             (wr_stb_o),
        .wr_we_o              (wr_we_o),
        .wr_addr_o            (wr_addr_o),
        .wr_dat_o             (wr_dat_o),
        .wr_cti_o             (wr_cti_o),
        .wr_ack_i             (wr_ack_i),
        .hdr_o                (hdr_o),
        .receive_count_o      (receive_count_o),
        .receive_busy_o       (receive_busy_o),
        .receive_done_o       (receive_done_o),
        .recv_state_o         (recv_state)
    );

endmodule

`default_nettype wire

// ==== source/receive_dma.sv ====
`default_nettype none
`include "dma_cfg.svh"

module receive_dma
    import dma_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   receive_start_i,
    input  wire [`DMA_AW-1:0]     receive_start_addr_i,
    input  wire [`DMA_SIZEW-1:0]  max_buff_size_i,
    output logic                  pop_o,
    input  wire [`DMA_DW-1:0]     head_dat_i,
    input  wire                   head_tail_i,
    input  wire                   fifo_empty_i,
    output logic                  wr_cyc_o,
    output logic                  wr_stb_o,
    output logic                  wr_we_o,
    output logic [`DMA_AW-1:0]    wr_addr_o,
    output logic [`DMA_DW-1:0]    wr_dat_o,
    output cti_t                  wr_cti_o,
    input  wire                   wr_ack_i,
    output logic [`DMA_DW-1:0]    hdr_o,
    output logic [`DMA_SIZEW-1:0] receive_count_o,
    output logic                  receive_busy_o,
    output logic                  receive_done_o,
    output recv_state_t           recv_state_o
);

    recv_state_t state, state_next;
    logic [`DMA_SIZEW-1:0] count;
    logic [`DMA_SIZEW-1:0] max_q;
    logic [`DMA_AW-1:0]    addr_q;
    logic [`DMA_DW-1:0]    flit_dat;    // flit taken from the buffer
    logic                  flit_tail;
    logic                  hdr_seen;
    logic                  eob_hold;    // keeps END_OF_BURST until ack
    logic                  start_go;
    logic                  write_flit;
    logic                  flit_done;

    assign start_go   = (state == RECV_IDLE) && receive_start_i;
    assign write_flit = (state == RECV_ACTIVE) && hdr_seen && (count < max_q);
    assign flit_done  = (state == RECV_ACTIVE) && (!write_flit || wr_ack_i);

    assign wr_cyc_o        = write_flit;
    assign wr_stb_o        = wr_cyc_o;
    assign wr_we_o         = 1'b1;
    assign wr_addr_o       = addr_q + `DMA_AW'(count);
    assign wr_dat_o        = flit_dat;
    assign receive_count_o = count;
    assign recv_state_o    = state;

    always_comb begin
        if (flit_tail || fifo_empty_i || eob_hold)
            wr_cti_o = END_OF_BURST;
        else
            wr_cti_o = CONST_ADDR_BURST;
    end

    always_comb begin
        state_next     = state;
        pop_o          = 1'b0;
        receive_done_o = 1'b0;
        case (state)
            RECV_IDLE: begin
                if (receive_start_i)
                    state_next = RECV_READ_FIFO;
            end
            RECV_READ_FIFO: begin
                if (!fifo_empty_i) begin
                    pop_o      = 1'b1;
                    state_next = RECV_ACTIVE;
                end
            end
            RECV_ACTIVE: begin
                if (flit_done) begin
                    if (flit_tail) begin
                        receive_done_o = 1'b1;
                        state_next     = RECV_IDLE;
                    end else if (fifo_empty_i) begin
                        state_next = RECV_RELEASE;
                    end else begin
                        pop_o = 1'b1;   // next flit straight away
                    end
                end
            end
            RECV_RELEASE: begin
                if (!fifo_empty_i)
                    state_next = RECV_READ_FIFO;
            end
            default: state_next = RECV_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= RECV_IDLE;
            count          <= '0;
            hdr_seen       <= 1'b0;
            eob_hold       <= 1'b0;
            receive_busy_o <= 1'b0;
        end else begin
            state    <= state_next;
            eob_hold <= wr_cyc_o && !wr_ack_i && (wr_cti_o == END_OF_BURST);
            if (start_go) begin
                count          <= '0;
                hdr_seen       <= 1'b0;
                receive_busy_o <= 1'b1;
            end else begin
                if (write_flit && wr_ack_i)
                    count <= count + 1'b1;   // stops at max_q
                if (state == RECV_ACTIVE)
                    hdr_seen <= 1'b1;
            end
            if (receive_done_o)
                receive_busy_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_go) begin
            addr_q <= receive_start_addr_i;
            max_q  <= max_buff_size_i;
        end
        if (pop_o) begin
            flit_dat  <= head_dat_i;
            flit_tail <= head_tail_i;
        end
        if (state == RECV_ACTIVE && !hdr_seen)
            hdr_o <= flit_dat;   // first flit is header info
    end

endmodule

`default_nettype wire

// ==== source/send_dma.sv ====
`default_nettype none
`include "dma_cfg.svh"

module send_dma
    import dma_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  send_start_i,
    input  wire [`DMA_AW-1:0]    send_start_addr_i,
    input  wire [`DMA_SIZEW-1:0] send_data_size_i,
    input  wire [`DMA_DW-1:0]    send_hdr_i,
    output logic                 rd_cyc_o,
    output logic                 rd_stb_o,
    output logic [`DMA_AW-1:0]   rd_addr_o,
    output cti_t                 rd_cti_o,
    input  wire [`DMA_DW-1:0]    rd_dat_i,
    input  wire                  rd_ack_i,
    output logic                 push_o,
    output logic [`DMA_DW-1:0]   push_dat_o,
    output logic                 push_tail_o,
    input  wire                  fifo_full_i,
    output logic                 send_busy_o,
    output logic                 send_done_o,
    output send_state_t          send_state_o
);

    send_state_t state, state_next;
    send_state_t ret_state;              // where to go once the buffer drains
    logic [`DMA_SIZEW-1:0] count;
    logic [`DMA_SIZEW-1:0] size_q;
    logic [`DMA_AW-1:0]    addr_q;
    logic [`DMA_DW-1:0]    hdr_q;
    logic                  start_ok;
    logic                  last_word;

    assign start_ok     = send_start_i && (send_data_size_i != '0);   // zero size is dropped
    assign last_word    = (count == size_q - 1'b1);
    assign rd_addr_o    = addr_q + `DMA_AW'(count);
    assign rd_stb_o     = rd_cyc_o;
    assign send_state_o = state;

    always_comb begin
        state_next  = state;
        rd_cyc_o    = 1'b0;
        rd_cti_o    = CONST_ADDR_BURST;
        push_o      = 1'b0;
        push_dat_o  = rd_dat_i;   // body flits come straight off the bus
        push_tail_o = 1'b0;
        send_done_o = 1'b0;
        case (state)
            SEND_IDLE: begin
                if (start_ok)
                    state_next = SEND_HDR;
            end
            SEND_HDR: begin
                push_dat_o = hdr_q;
                if (fifo_full_i) begin
                    state_next = SEND_WAIT;
                end else begin
                    push_o     = 1'b1;
                    state_next = SEND_BODY;
                end
            end
            SEND_BODY: begin
                if (fifo_full_i) begin
                    state_next = SEND_WAIT;   // no read cycle without room
                end else begin
                    rd_cyc_o = 1'b1;
                    if (last_word)
                        rd_cti_o = END_OF_BURST;
                    if (rd_ack_i) begin
                        push_o      = 1'b1;
                        push_tail_o = last_word;
                        if (last_word) begin
                            send_done_o = 1'b1;
                            state_next  = SEND_IDLE;
                        end
                    end
                end
            end
            SEND_WAIT: begin
                if (!fifo_full_i)
                    state_next = ret_state;
            end
            default: state_next = SEND_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= SEND_IDLE;
            ret_state   <= SEND_HDR;
            count       <= '0;
            send_busy_o <= 1'b0;
        end else begin
            state <= state_next;
            if (state == SEND_IDLE && start_ok) begin
                count       <= '0;
                send_busy_o <= 1'b1;
            end else if (push_o && state == SEND_BODY) begin
                count <= count + 1'b1;   // one word per ack
            end
            if (send_done_o)
                send_busy_o <= 1'b0;
            if (state_next == SEND_WAIT && state != SEND_WAIT)
                ret_state <= state;
        end
    end

    // transfer parameters held for the whole send
    always_ff @(posedge clk) begin
        if (state == SEND_IDLE && start_ok) begin
            addr_q <= send_start_addr_i;
            size_q <= send_data_size_i;
            hdr_q  <= send_hdr_i;
        end
    end

endmodule

`default_nettype wire

// ==== test/ni_dma_chk.sv ====
`default_nettype none
`include "dma_cfg.svh"

module ni_dma_chk (
    input wire               clk,
    input wire               reset,
    input wire               rd_cyc_o,
    input wire               rd_stb_o,
    input wire [`DMA_AW-1:0] rd_addr_o,
    input wire               rd_ack_i,
    input wire               wr_cyc_o,
    input wire               wr_stb_o,
    input wire [`DMA_AW-1:0] wr_addr_o,
    input wire               wr_ack_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // stb travels with cyc on both masters
    rd_stb_match: assert property (@(posedge clk) disable iff (reset) rd_stb_o == rd_cyc_o)
        else $error("read master stb differs from cyc");
    wr_stb_match: assert property (@(posedge clk) disable iff (reset) wr_stb_o == wr_cyc_o)
        else $error("write master stb differs from cyc");

    rd_addr_hold: assert property (@(posedge clk) disable iff (reset)
        rd_cyc_o && !rd_ack_i |=> $stable(rd_addr_o))
        else $error("read address moved before ack");
    wr_addr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_cyc_o && !wr_ack_i |=> $stable(wr_addr_o))
        else $error("write address moved before ack");

    // send side comes out of reset idle
    rd_quiet_after_reset: assert property (@(posedge clk) reset |=> !rd_cyc_o)
        else $error("read cycle raised right after reset");

endmodule

bind ni_dma_top ni_dma_chk ni_dma_chk_i (.*);

`default_nettype wire

// ==== test/ni_dma_tb.sv ====
`default_nettype none
`include "dma_cfg.svh"

module ni_dma_tb
    import dma_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS = 7;
    localparam logic [31:0] RD_KEY = 32'h5a5a_c3c3;   // read memory pattern

    typedef struct packed {
        logic [`DMA_SIZEW-1:0] len;
        logic [`DMA_SIZEW-1:0] max_len;
        logic [`DMA_AW-1:0]    tx_addr;
        logic [`DMA_AW-1:0]    rx_addr;
        logic [`DMA_DW-1:0]    hdr;
        logic [7:0]            delay;      // cycles before receive start
    } row_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  send_start_i;
    logic [`DMA_AW-1:0]    send_start_addr_i;
    logic [`DMA_SIZEW-1:0] send_data_size_i;
    logic [`DMA_DW-1:0]    send_hdr_i;
    logic                  rd_cyc_o, rd_stb_o;
    logic [`DMA_AW-1:0]    rd_addr_o;
    cti_t                  rd_cti_o;
    logic [`DMA_DW-1:0]    rd_dat_i = '0;
    logic                  rd_ack_i = 1'b0;
    logic                  send_busy_o, send_done_o;
    logic                  receive_start_i;
    logic [`DMA_AW-1:0]    receive_start_addr_i;
    logic [`DMA_SIZEW-1:0] max_buff_size_i;
    logic                  wr_cyc_o, wr_stb_o, wr_we_o;
    logic [`DMA_AW-1:0]    wr_addr_o;
    logic [`DMA_DW-1:0]    wr_dat_o;
    cti_t                  wr_cti_o;
    logic                  wr_ack_i = 1'b0;
    logic [`DMA_DW-1:0]    hdr_o;
    logic [`DMA_SIZEW-1:0] receive_count_o;
    logic                  receive_busy_o, receive_done_o;
    logic [7:0]            status_o;

    row_t               tests [NROWS];
    row_t               cur = '0;         // row in flight, for the bus models
    logic [31:0]        lfsr = 32'h6c88_6486;
    logic [1:0]         rd_wait = '0;
    logic [1:0]         wr_wait = '0;
    logic [`DMA_DW-1:0] wr_mem [1024];
    int                 wr_tag [1024];    // test that last wrote the word, 0 for none
    int                 test_no = 0;
    int                 errors = 0;
    int                 passed = 0;
    int                 limit = 0;
    int                 cycles = 0;
    logic               send_seen = 1'b1;
    logic               recv_seen = 1'b1;

    ni_dma_top ni_dma_top_i (
        .clk(clk), .reset(reset),
        .send_start_i(send_start_i), .send_start_addr_i(send_start_addr_i),
        .send_data_size_i(send_data_size_i), .send_hdr_i(send_hdr_i),
        .rd_cyc_o(rd_cyc_o), .rd_stb_o(rd_stb_o), .rd_addr_o(rd_addr_o), .rd_cti_o(rd_cti_o),
        .rd_dat_i(rd_dat_i), .rd_ack_i(rd_ack_i),
        .send_busy_o(send_busy_o), .send_done_o(send_done_o),
        .receive_start_i(receive_start_i), .receive_start_addr_i(receive_start_addr_i),
        .max_buff_size_i(max_buff_size_i),
        .wr_cyc_o(wr_cyc_o), .wr_stb_o(wr_stb_o), .wr_we_o(wr_we_o), .wr_addr_o(wr_addr_o),
        .wr_dat_o(wr_dat_o), .wr_cti_o(wr_cti_o), .wr_ack_i(wr_ack_i),
        .hdr_o(hdr_o), .receive_count_o(receive_count_o),
        .receive_busy_o(receive_busy_o), .receive_done_o(receive_done_o),
        .status_o(status_o)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [`DMA_DW-1:0] read_word(input logic [`DMA_AW-1:0] a);
        return a ^ RD_KEY;
    endfunction

    task automatic draw_delay(output logic [1:0] d);
        for (int b = 0; b < 2; b++) begin
            d[b] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("test %0d at %0d ns: %s", test_no, $time, msg);
        errors++;
    endtask

    // both bus slaves, ack 1 to 4 cycles after cyc rises
    always @(posedge clk or posedge reset) begin : bus_models
        logic [1:0] d;
        if (reset) begin
            rd_ack_i <= 1'b0;
            wr_ack_i <= 1'b0;
        end else begin
            if (rd_cyc_o && !rd_ack_i) begin
                if (rd_wait == 0) begin
                    rd_ack_i <= 1'b1;
                    rd_dat_i <= read_word(rd_addr_o);
                    // last word of the block closes the burst
                    if (rd_addr_o == cur.tx_addr + `DMA_AW'(cur.len) - 1) begin
                        if (rd_cti_o !== END_OF_BURST)
                            report_mismatch("rd_cti_o", rd_cti_o, END_OF_BURST);
                    end else if (rd_cti_o !== CONST_ADDR_BURST) begin
                        report_mismatch("rd_cti_o", rd_cti_o, CONST_ADDR_BURST);
                    end
                end else begin
                    rd_wait <= rd_wait - 1'b1;
                end
            end else begin
                rd_ack_i <= 1'b0;
                draw_delay(d);
                rd_wait <= d;
            end
            if (wr_cyc_o && !wr_ack_i) begin
                if (wr_wait == 0) begin
                    wr_ack_i <= 1'b1;
                    wr_mem[wr_addr_o[9:0]] <= wr_dat_o;
                    wr_tag[wr_addr_o[9:0]] <= test_no;
                    if (wr_we_o !== 1'b1)
                        report_mismatch("wr_we_o", wr_we_o, 1);
                    // tail word must end the burst, others may end early on an empty buffer
                    if (wr_addr_o == cur.rx_addr + `DMA_AW'(cur.len) - 1) begin
                        if (wr_cti_o !== END_OF_BURST)
                            report_mismatch("wr_cti_o", wr_cti_o, END_OF_BURST);
                    end else if (wr_cti_o !== CONST_ADDR_BURST
                                 && wr_cti_o !== END_OF_BURST) begin
                        report_failure("write cycle with an unexpected cycle type");
                    end
                end else begin
                    wr_wait <= wr_wait - 1'b1;
                end
            end else begin
                wr_ack_i <= 1'b0;
                draw_delay(d);
                wr_wait <= d;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == limit) begin
            if (!send_seen)
                $display("Timeout in test %0d: send_done_o never came", test_no);
            if (!recv_seen)
                $display("Timeout in test %0d: receive_done_o never came", test_no);
            if (send_seen && recv_seen)
                $display("Timeout in test %0d: run went past %0d cycles", test_no, limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic load_table();
        tests[0] = '{10'd4,  10'd16, 32'h0000_1000, 32'h0000_0100, 32'hc0de_0001, 8'd2};
        tests[1] = '{10'd12, 10'd8,  32'h0000_2000, 32'h0000_0140, 32'hc0de_0002, 8'd3};
        tests[2] = '{10'd14, 10'd20, 32'h0000_3000, 32'h0000_0180, 32'hc0de_0003, 8'd60};
        tests[3] = '{10'd0,  10'd8,  32'h0000_4000, 32'h0000_01c0, 32'hc0de_0004, 8'd2};
        tests[4] = '{10'd1,  10'd4,  32'h0000_5000, 32'h0000_0200, 32'hc0de_0005, 8'd1};
        tests[5] = '{10'd7,  10'd7,  32'h0000_6000, 32'h0000_0240, 32'hc0de_0006, 8'd1};
        tests[6] = '{10'd9,  10'd32, 32'h0000_7000, 32'h0000_0280, 32'hc0de_0007, 8'd5};
    endtask

    task automatic check_transfer(input row_t r, input logic saw_wait);
        int         n_exp;
        logic [9:0] idx;
        n_exp = (r.len < r.max_len) ? r.len : r.max_len;   // words that fit
        if (hdr_o !== r.hdr)
            report_mismatch("hdr_o", hdr_o, r.hdr);
        if (receive_count_o !== `DMA_SIZEW'(n_exp))
            report_mismatch("receive_count_o", receive_count_o, n_exp);
        for (int i = 0; i < r.len; i++) begin
            idx = r.rx_addr[9:0] + 10'(i);
            if (i >= n_exp) begin
                if (wr_tag[idx] == test_no)
                    report_failure($sformatf("word %0d beyond the limit was written", i));
            end else if (wr_tag[idx] != test_no) begin
                report_failure($sformatf("word %0d never reached the receive memory", i));
            end else if (wr_mem[idx] !== read_word(r.tx_addr + i)) begin
                report_mismatch($sformatf("wr_mem[%0h]", idx), wr_mem[idx],
                                read_word(r.tx_addr + i));
            end
        end
        if (status_o !== {RECV_IDLE, SEND_IDLE})
            report_mismatch("status_o", status_o, {RECV_IDLE, SEND_IDLE});
        if (send_busy_o !== 1'b0)
            report_mismatch("send_busy_o", send_busy_o, 0);
        if (receive_busy_o !== 1'b0)
            report_mismatch("receive_busy_o", receive_busy_o, 0);
        // each read takes at most 5 cycles, so this delay always fills the buffer
        if (r.delay >= 6 * `DMA_FIFO_DEPTH && r.len >= `DMA_FIFO_DEPTH && !saw_wait)
            report_failure("send side never stalled on a full buffer");
    endtask

    task automatic run_transfer(input row_t r);
        int   cyc;
        logic saw_wait;
        cyc       = 0;
        saw_wait  = 1'b0;
        send_seen = 1'b0;
        recv_seen = 1'b0;
        cur       = r;
        @(posedge clk);
        send_start_i         <= 1'b1;
        send_start_addr_i    <= r.tx_addr;
        send_data_size_i     <= r.len;
        send_hdr_i           <= r.hdr;
        receive_start_addr_i <= r.rx_addr;
        max_buff_size_i      <= r.max_len;
        while (!(send_seen && recv_seen)) begin
            @(posedge clk);
            cyc++;
            send_start_i    <= 1'b0;
            receive_start_i <= (cyc == r.delay);
            if (status_o[3:0] == SEND_WAIT)
                saw_wait = 1'b1;
            if (!send_seen && cyc >= 2 && send_busy_o !== 1'b1)
                report_mismatch("send_busy_o", send_busy_o, 1);
            if (!recv_seen && cyc >= r.delay + 2 && receive_busy_o !== 1'b1)
                report_mismatch("receive_busy_o", receive_busy_o, 1);
            if (send_done_o)
                send_seen = 1'b1;
            if (receive_done_o)
                recv_seen = 1'b1;
        end
        @(posedge clk);   // both FSMs back in idle
        check_transfer(r, saw_wait);
    endtask

    task automatic run_zero_size(input row_t r);
        send_seen = 1'b1;   // no done pulse due
        recv_seen = 1'b1;
        @(posedge clk);
        send_start_i      <= 1'b1;
        send_start_addr_i <= r.tx_addr;
        send_data_size_i  <= r.len;
        send_hdr_i        <= r.hdr;
        @(posedge clk);
        send_start_i <= 1'b0;
        repeat (8) begin
            @(posedge clk);
            if (rd_cyc_o)
                report_failure("read cycle issued for a zero-size send");
            if (send_busy_o !== 1'b0)
                report_mismatch("send_busy_o", send_busy_o, 0);
        end
        if (status_o !== {RECV_IDLE, SEND_IDLE})
            report_mismatch("status_o", status_o, {RECV_IDLE, SEND_IDLE});
    endtask

    initial begin : main
        int errs_before;
        load_table();
        foreach (tests[i])
            limit += int'(tests[i].len + tests[i].delay) * 8;
        limit += 16;   // reset and the gaps between rows
        reset                = 1'b1;
        send_start_i         = 1'b0;
        send_start_addr_i    = '0;
        send_data_size_i     = '0;
        send_hdr_i           = '0;
        receive_start_i      = 1'b0;
        receive_start_addr_i = '0;
        max_buff_size_i      = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int t = 0; t < NROWS; t++) begin
            test_no     = t + 1;
            errs_before = errors;
            if (tests[t].len == 0)
                run_zero_size(tests[t]);
            else
                run_transfer(tests[t]);
            if (errors == errs_before)
                passed++;
            $display("test %0d: len %0d, limit %0d, delay %0d, %s", test_no, tests[t].len,
                     tests[t].max_len, tests[t].delay,
                     (errors == errs_before) ? "ok" : "errors");
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", NROWS, passed,
                 NROWS - passed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
